// ==== verilog/req_sort_defines.svh ====
`ifndef REQ_SORT_DEFINES_SVH
`define REQ_SORT_DEFINES_SVH

// request field widths
`define REQ_ADDR_BITS  8    // row address carried by every request
`define REQ_INDEX_BITS 7    // request index, returned with the drained entry

// queue geometry
`define NUM_QUEUES     4    // number of per-row read queues
`define QUEUE_DEPTH    4    // entries held by each queue

// kind bit encoding, sampled with req_valid
`define KIND_READ      1'b1 // read request, sorted into a queue
`define KIND_WRITE     1'b0 // write request, dropped and reported

`endif

// ==== verilog/req_sort_pkg.sv ====
`default_nettype none

`include "req_sort_defines.svh"

package req_sort_pkg;

    typedef logic [`REQ_ADDR_BITS-1:0] addr_t;                     // row address
    typedef logic [`REQ_INDEX_BITS-1:0] index_t;                   // request index

    // a queued entry keeps the address in the upper bits and the index below it
    typedef logic [`REQ_ADDR_BITS+`REQ_INDEX_BITS-1:0] entry_t;

    typedef logic [$clog2(`NUM_QUEUES)-1:0] qsel_t;                // queue number
    typedef logic [$clog2(`QUEUE_DEPTH):0] level_t;                // free entries, 0 up to depth
    typedef logic [`NUM_QUEUES-1:0] qmask_t;                       // one bit per queue

endpackage

`default_nettype wire

// ==== verilog/req_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
    parameter int DEPTH = 4,                                   // number of entries
    parameter int WIDTH = 15                                   // entry width in bits
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                push,                     // enqueue push_data on this edge
    input  wire logic [WIDTH-1:0]    push_data,
    input  wire logic                pop,                      // dequeue the head on this edge
    output logic [WIDTH-1:0]         pop_data,                 // head entry, valid while not empty
    output logic                     empty,
    output req_sort_pkg::level_t     level                     // free entries left
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;    // pointer width, at least one bit
    localparam int CNT_W = $clog2(DEPTH + 1);                  // count runs from 0 to DEPTH

    logic [WIDTH-1:0] mem [DEPTH];                             // entry storage, no reset needed
    logic [PTR_W-1:0] wr_ptr;                                  // next slot to write
    logic [PTR_W-1:0] rd_ptr;                                  // slot of the head entry
    logic [CNT_W-1:0] count;                                   // entries currently held
    logic             full;
    logic             do_push;                                 // push that is actually taken
    logic             do_pop;                                  // pop that is actually taken

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;                            // a push into a full queue is lost
    assign do_pop  = pop && !empty;                            // a pop of an empty queue does nothing

    assign pop_data = mem[rd_ptr];                             // head shows without a cycle of delay
    assign level    = req_sort_pkg::level_t'(DEPTH - count);   // free entries, not fill level

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;                          // payload only, control lives below
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;                                      // queue starts empty, level reads DEPTH
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // circular wrap
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;                // push only
                2'b01:   count <= count - 1'b1;                // pop only
                default: count <= count;                       // both or neither keep the count
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/row_tag_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "req_sort_defines.svh"

module row_tag_table (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire req_sort_pkg::addr_t   req_addr,    // address of the request in flight
    input  wire req_sort_pkg::qmask_t  push,        // one-hot queue being pushed, or zero
    input  wire req_sort_pkg::qmask_t  pop,         // one-hot queue being popped, or zero
    input  wire req_sort_pkg::qmask_t  last_one,    // queues that hold exactly one entry
    output req_sort_pkg::qmask_t       hit          // queues whose last row matches req_addr
);

    req_sort_pkg::addr_t  tags [`NUM_QUEUES];       // last address pushed into each queue
    req_sort_pkg::qmask_t tag_valid;                // tag belongs to a queue with entries

    // all tags are compared at once, so the hit vector is ready in the request cycle
    always_comb begin
        for (int i = 0; i < `NUM_QUEUES; i++) begin
            hit[i] = tag_valid[i] && (tags[i] == req_addr); // stale tags never match
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_QUEUES; i++) begin
            if (push[i]) begin
                tags[i] <= req_addr;                // the newest row of that queue wins
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_valid <= '0;                        // no queue has a row after reset
        end else begin
            for (int i = 0; i < `NUM_QUEUES; i++) begin
                if (push[i]) begin
                    tag_valid[i] <= 1'b1;           // a push keeps the tag alive even with a pop
                end else if (pop[i] && last_one[i]) begin
                    tag_valid[i] <= 1'b0;           // the queue drains dry on this edge
                end
            end
        end
    end

    // the table only tracks rows, the queues themselves decide when a pop is legal
    // so last_one arrives already qualified from the level of each queue

endmodule

`default_nettype wire

// ==== verilog/sort_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "req_sort_defines.svh"

module sort_ctrl (
    input  wire logic                                      clk,
    input  wire logic                                      reset,
    input  wire logic                                      req_valid,  // one-cycle request strobe
    input  wire req_sort_pkg::addr_t                       req_addr,
    input  wire req_sort_pkg::index_t                      req_index,
    input  wire logic                                      req_kind,   // read or write
    input  wire req_sort_pkg::qmask_t                      hit,        // row matches from the table
    input  wire req_sort_pkg::level_t [`NUM_QUEUES-1:0]    levels,     // free entries per queue
    input  wire req_sort_pkg::qmask_t                      empty,
    output req_sort_pkg::qmask_t                           push,       // one-hot target, or zero
    output req_sort_pkg::entry_t                           push_entry, // packed entry for the queues
    output logic                                           write_drop,
    output logic                                           overflow_drop
);

    logic                  is_read;                 // a read is offered this cycle
    logic                  is_write;                // a write is offered and will be dropped
    req_sort_pkg::qmask_t  full;                    // queues with no free entry
    req_sort_pkg::qmask_t  cand;                    // queues that may take a row hit
    logic                  hit_found;               // at least one hit candidate exists
    req_sort_pkg::qsel_t   hit_q;                   // lowest hit candidate
    req_sort_pkg::qsel_t   best_q;                  // queue with most free entries
    req_sort_pkg::level_t  best_level;              // its free-entry count
    req_sort_pkg::qsel_t   target;                  // final choice
    logic                  no_room;                 // every queue is full

    assign is_read    = req_valid && (req_kind == `KIND_READ);
    assign is_write   = req_valid && (req_kind == `KIND_WRITE);
    assign push_entry = {req_addr, req_index};      // address on top, index below

    always_comb begin
        hit_found  = 1'b0;
        hit_q      = '0;
        best_q     = '0;
        best_level = '0;
        for (int i = 0; i < `NUM_QUEUES; i++) begin
            full[i] = (levels[i] == '0);            // level counts free entries, zero means full
        end
        cand = hit & ~empty & ~full;                // same row and still room behind it
        for (int i = 0; i < `NUM_QUEUES; i++) begin
            if (cand[i] && !hit_found) begin
                hit_q     = req_sort_pkg::qsel_t'(i); // first match keeps the lowest index
                hit_found = 1'b1;
            end
        end
        for (int i = 0; i < `NUM_QUEUES; i++) begin
            if (levels[i] > best_level) begin       // strict compare keeps ties on the lower queue
                best_level = levels[i];
                best_q     = req_sort_pkg::qsel_t'(i);
            end
        end
        no_room = (best_level == '0);               // a hit candidate implies some room anyway
        target  = hit_found ? hit_q : best_q;
    end

    // push lands on the same edge that samples req_valid
    always_comb begin
        push = '0;
        if (is_read && !no_room) begin
            push[target] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            write_drop    <= 1'b0;
            overflow_drop <= 1'b0;
        end else begin
            write_drop    <= is_write;              // reported one cycle after the request
            overflow_drop <= is_read && no_room;    // read with nowhere to go
        end
    end

endmodule

`default_nettype wire

// ==== verilog/drain_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "req_sort_defines.svh"

module drain_arbiter (
    input  wire logic                                      clk,
    input  wire logic                                      reset,
    input  wire logic                                      drain_en,  // level enable, no handshake
    input  wire req_sort_pkg::qmask_t                      empty,
    input  wire req_sort_pkg::entry_t [`NUM_QUEUES-1:0]    heads,     // head entry of each queue
    output req_sort_pkg::qmask_t                           pop,       // one-hot dequeue, or zero
    output logic                                           out_valid, // one cycle per drained entry
    output req_sort_pkg::addr_t                            out_addr,
    output req_sort_pkg::index_t                           out_index,
    output req_sort_pkg::qsel_t                            out_queue  // queue the entry came from
);

    req_sort_pkg::qsel_t last_grant;                // queue served most recently
    req_sort_pkg::qsel_t grant;                     // next queue in circular order with data
    logic                any_ready;                 // some queue holds an entry
    logic                fire;                      // a pop happens on this edge

    // search starts one past the last grant and wraps around once
    always_comb begin
        int idx;
        grant     = last_grant;
        any_ready = 1'b0;
        for (int k = 1; k <= `NUM_QUEUES; k++) begin
            idx = (int'(last_grant) + k) % `NUM_QUEUES;
            if (!any_ready && !empty[idx]) begin
                grant     = req_sort_pkg::qsel_t'(idx); // first non-empty queue wins
                any_ready = 1'b1;
            end
        end
    end

    assign fire = drain_en && any_ready;

    always_comb begin
        pop = '0;
        if (fire) begin
            pop[grant] = 1'b1;                      // queues dequeue on the same edge
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            last_grant <= req_sort_pkg::qsel_t'(`NUM_QUEUES - 1); // queue 0 is served first
        end else begin
            out_valid <= fire;
            if (fire) begin
                last_grant <= grant;                // pointer only moves on a real grant
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            {out_addr, out_index} <= heads[grant];  // unpack the entry as it leaves the queue
            out_queue             <= grant;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/req_sort_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "req_sort_defines.svh"

module req_sort_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   req_valid,     // one-cycle request strobe
    input  wire req_sort_pkg::addr_t    req_addr,
    input  wire req_sort_pkg::index_t   req_index,
    input  wire logic                   req_kind,      // read or write
    input  wire logic                   drain_en,      // drain while high
    output logic                        out_valid,
    output req_sort_pkg::addr_t         out_addr,
    output req_sort_pkg::index_t        out_index,
    output req_sort_pkg::qsel_t         out_queue,
    output logic                        write_drop,
    output logic                        overflow_drop,
    output logic                        all_empty      // nothing queued anywhere
);

    req_sort_pkg::qmask_t                    hit;        // row matches against req_addr
    req_sort_pkg::qmask_t                    push;       // target queue of the current read
    req_sort_pkg::qmask_t                    pop;        // queue drained this cycle
    req_sort_pkg::qmask_t                    empty_mask; // empty flag of each queue
    req_sort_pkg::qmask_t                    last_one;   // queues down to a single entry
    req_sort_pkg::level_t [`NUM_QUEUES-1:0]  levels;     // free entries of each queue
    req_sort_pkg::entry_t [`NUM_QUEUES-1:0]  heads;      // head entry of each queue
    req_sort_pkg::entry_t                    push_entry; // entry written by a push

    sort_ctrl sort_ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_index     (req_index),
        .req_kind      (req_kind),
        .hit           (hit),
        .levels        (levels),
        .empty         (empty_mask),
        .push          (push),
        .push_entry    (push_entry),
        .write_drop    (write_drop),
        .overflow_drop (overflow_drop)
    );

    row_tag_table row_tag_table_i (
        .clk      (clk),
        .reset    (reset),
        .req_addr (req_addr),
        .push     (push),
        .pop      (pop),
        .last_one (last_one),
        .hit      (hit)
    );

    for (genvar i = 0; i < `NUM_QUEUES; i++) begin : g_queue
        req_queue #(
            .DEPTH (`QUEUE_DEPTH),
            .WIDTH ($bits(req_sort_pkg::entry_t))
        ) req_queue_i (
            .clk       (clk),
            .reset     (reset),
            .push      (push[i]),
            .push_data (push_entry),              // every queue sees the entry, push picks one
            .pop       (pop[i]),
            .pop_data  (heads[i]),
            .empty     (empty_mask[i]),
            .level     (levels[i])
        );
        // one entry left means one below the full free count
        assign last_one[i] = (levels[i] == req_sort_pkg::level_t'(`QUEUE_DEPTH - 1));
    end

    drain_arbiter drain_arbiter_i (
        .clk       (clk),
        .reset     (reset),
        .drain_en  (drain_en),
        .empty     (empty_mask),
        .heads     (heads),
        .pop       (pop),
        .out_valid (out_valid),
        .out_addr  (out_addr),
        .out_index (out_index),
        .out_queue (out_queue)
    );

    assign all_empty = &empty_mask;               // level output, high straight after reset

endmodule

`default_nettype wire

// ==== bench/req_sort_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "req_sort_defines.svh"

module req_sort_tb;

    localparam int DROP_WRITE    = 4;                   // reference result for a dropped write
    localparam int DROP_OVERFLOW = 5;                   // reference result for a read with no room
    localparam int DRAIN_LIMIT   = 200;                 // cycles allowed for one full drain

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    req_sort_pkg::addr_t   req_addr;
    req_sort_pkg::index_t  req_index;
    logic                  req_kind;
    logic                  drain_en;
    logic                  out_valid;
    req_sort_pkg::addr_t   out_addr;
    req_sort_pkg::index_t  out_index;
    req_sort_pkg::qsel_t   out_queue;
    logic                  write_drop;
    logic                  overflow_drop;
    logic                  all_empty;

    // model of the four queues, kept as separate address and index columns
    req_sort_pkg::addr_t   model_addr [`NUM_QUEUES][`QUEUE_DEPTH];
    req_sort_pkg::index_t  model_idx  [`NUM_QUEUES][`QUEUE_DEPTH];
    int                    model_cnt  [`NUM_QUEUES];    // entries held by each model queue
    req_sort_pkg::addr_t   model_tag  [`NUM_QUEUES];    // last address pushed into each queue
    int                    model_last;                  // queue granted most recently
    logic [31:0]           lfsr_state;                  // random source for the bursts
    req_sort_pkg::index_t  next_index;                  // running request index
    logic                  cur_write;                   // request driven now is a write
    logic                  cur_overflow;                // request driven now should overflow
    logic                  exp_write_drop;              // write_drop due this cycle
    logic                  exp_overflow_drop;           // overflow_drop due this cycle
    logic                  drain_sampled;               // drain_en as seen by the last edge

    req_sort_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_index     (req_index),
        .req_kind      (req_kind),
        .drain_en      (drain_en),
        .out_valid     (out_valid),
        .out_addr      (out_addr),
        .out_index     (out_index),
        .out_queue     (out_queue),
        .write_drop    (write_drop),
        .overflow_drop (overflow_drop),
        .all_empty     (all_empty)
    );

    always #2 clk = ~clk;                               // 4 ns period

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        stop_run();
    endtask

    task automatic fail_text(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};               // one step per bit taken
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // decision rule: row hit first, then most free entries, else overflow
    function automatic int choose_queue(input logic kind, input req_sort_pkg::addr_t addr);
        int best;
        int best_room;
        int room;
        if (kind == `KIND_WRITE) begin
            return DROP_WRITE;
        end
        for (int q = 0; q < `NUM_QUEUES; q++) begin
            if (model_cnt[q] > 0 && model_cnt[q] < `QUEUE_DEPTH && model_tag[q] == addr) begin
                return q;                               // lowest queue with the same open row
            end
        end
        best      = 0;
        best_room = 0;
        for (int q = 0; q < `NUM_QUEUES; q++) begin
            room = `QUEUE_DEPTH - model_cnt[q];
            if (room > best_room) begin
                best      = q;                          // strict compare keeps ties low
                best_room = room;
            end
        end
        return (best_room == 0) ? DROP_OVERFLOW : best;
    endfunction

    // next non-empty queue after the last grant, or -1 when everything is empty
    function automatic int next_grant(input int last);
        int q;
        for (int k = 1; k <= `NUM_QUEUES; k++) begin
            q = (last + k) % `NUM_QUEUES;
            if (model_cnt[q] > 0) begin
                return q;
            end
        end
        return -1;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;                                             // inputs change 1 ns after the edge
    endtask

    task automatic idle(input int n);
        req_valid    = 1'b0;
        cur_write    = 1'b0;
        cur_overflow = 1'b0;
        repeat (n) step();
    endtask

    task automatic send_req(input logic kind, input req_sort_pkg::addr_t addr, input int exp_q);
        int choice;
        choice = choose_queue(kind, addr);
        if (exp_q >= 0) begin
            assert (choice == exp_q) else fail_value("target_queue", choice, exp_q);
        end
        req_valid = 1'b1;
        req_addr  = addr;
        req_index = next_index;
        req_kind  = kind;
        if (choice < `NUM_QUEUES) begin
            model_addr[choice][model_cnt[choice]] = addr;
            model_idx[choice][model_cnt[choice]]  = next_index;
            model_cnt[choice]++;
            model_tag[choice] = addr;
        end
        cur_write    = (choice == DROP_WRITE);
        cur_overflow = (choice == DROP_OVERFLOW);
        next_index++;
        step();
    endtask

    task automatic drain_all();
        int waited;
        int queued;                                     // entries the model still holds
        idle(2);                                        // last push settles before the drain
        queued = 0;
        for (int q = 0; q < `NUM_QUEUES; q++) begin
            queued += model_cnt[q];
        end
        assert (all_empty == (queued == 0))
            else fail_value("all_empty", all_empty, queued == 0);
        drain_en = 1'b1;
        waited   = 0;
        while (!all_empty) begin
            step();
            waited++;
            if (waited > DRAIN_LIMIT) begin
                fail_text("timeout: all_empty never returned to 1 during the drain");
            end
        end
        drain_en = 1'b0;
        idle(2);
        for (int q = 0; q < `NUM_QUEUES; q++) begin
            assert (model_cnt[q] == 0) else fail_text("a queued request was never drained");
        end
    endtask

    // drop strobes are due one cycle after the request edge
    always @(posedge clk) begin
        if (reset) begin
            exp_write_drop    <= 1'b0;
            exp_overflow_drop <= 1'b0;
            drain_sampled     <= 1'b0;
        end else begin
            exp_write_drop    <= cur_write;
            exp_overflow_drop <= cur_overflow;
            drain_sampled     <= drain_en;
        end
    end

    // outputs are compared at the falling edge where they are stable
    always @(negedge clk) begin
        int g;
        if (!reset) begin
            assert (write_drop == exp_write_drop)
                else fail_value("write_drop", write_drop, exp_write_drop);
            assert (overflow_drop == exp_overflow_drop)
                else fail_value("overflow_drop", overflow_drop, exp_overflow_drop);
            g = next_grant(model_last);
            assert (out_valid == (drain_sampled && g >= 0))
                else fail_value("out_valid", out_valid, drain_sampled && g >= 0);
            if (out_valid) begin
                assert (out_queue == g) else fail_value("out_queue", out_queue, g);
                assert (out_addr == model_addr[g][0])
                    else fail_value("out_addr", out_addr, model_addr[g][0]);
                assert (out_index == model_idx[g][0])
                    else fail_value("out_index", out_index, model_idx[g][0]);
                for (int i = 1; i < `QUEUE_DEPTH; i++) begin
                    model_addr[g][i-1] = model_addr[g][i]; // head leaves, rest moves up
                    model_idx[g][i-1]  = model_idx[g][i];
                end
                model_cnt[g]--;
                model_last = g;
            end
        end
    end

    initial begin
        logic [31:0] n;
        logic [31:0] k;
        logic [31:0] a;
        clk          = 1'b0;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_index    = '0;
        req_kind     = `KIND_READ;
        drain_en     = 1'b0;
        cur_write    = 1'b0;
        cur_overflow = 1'b0;
        next_index   = '0;
        lfsr_state   = 32'h8ae2;
        model_last   = `NUM_QUEUES - 1;                 // queue 0 is granted first
        for (int q = 0; q < `NUM_QUEUES; q++) begin
            model_cnt[q] = 0;
            model_tag[q] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        assert (out_valid == 1'b0) else fail_value("out_valid", out_valid, 0);
        assert (write_drop == 1'b0) else fail_value("write_drop", write_drop, 0);
        assert (overflow_drop == 1'b0) else fail_value("overflow_drop", overflow_drop, 0);
        assert (all_empty == 1'b1) else fail_value("all_empty", all_empty, 1);

        for (int i = 0; i < 4; i++) begin
            send_req(`KIND_READ, 8'h55, 0);            // same row gathers in queue 0
        end
        send_req(`KIND_READ, 8'h55, 1);                // queue 0 full, most free is queue 1
        drain_all();

        for (int i = 0; i < 5; i++) begin
            send_req(`KIND_READ, 8'(i + 1), i % `NUM_QUEUES);
        end
        drain_all();

        send_req(`KIND_WRITE, 8'h77, DROP_WRITE);
        for (int i = 0; i < `NUM_QUEUES * `QUEUE_DEPTH; i++) begin
            send_req(`KIND_READ, 8'(8'h80 + i), i % `NUM_QUEUES);
        end
        send_req(`KIND_READ, 8'hc0, DROP_OVERFLOW);    // every queue is full now
        send_req(`KIND_WRITE, 8'h80, DROP_WRITE);
        drain_all();

        // random bursts over four rows, about one write in eight
        for (int round = 0; round < 40; round++) begin
            take_bits(4, n);
            for (int r = 0; r < int'(n) + 4; r++) begin
                take_bits(3, k);
                take_bits(2, a);
                send_req((k == 0) ? `KIND_WRITE : `KIND_READ, 8'(8'h30 + a), -1);
            end
            drain_all();
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/req_sort_pkg.sv
verilog/req_queue.sv
verilog/row_tag_table.sv
verilog/sort_ctrl.sv
verilog/drain_arbiter.sv
verilog/req_sort_top.sv
bench/req_sort_tb.sv

// ==== Bender.yml ====
package:
  name: req_sort

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/req_sort_pkg.sv
      - verilog/req_queue.sv
      - verilog/row_tag_table.sv
      - verilog/sort_ctrl.sv
      - verilog/drain_arbiter.sv
      - verilog/req_sort_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/req_sort_tb.sv
